//--- hdl/cpc_settings.svh
// CPC expansion constants for ROM page layout, Multiface ports and shadow store slots
`ifndef CPC_SETTINGS_SVH
`define CPC_SETTINGS_SVH

// System ROM target pages in the 8 MB memory map
`define CPC_PAGE_OS         9'h000
`define CPC_PAGE_BASIC      9'h100
`define CPC_PAGE_AMSDOS     9'h107
`define CPC_PAGE_MF2        9'h0FF
`define CPC_PAGE_BADEXT     9'h1EE
`define CPC_PAGE_COMBO_END  9'h1FF

// Memory slot divider, one slot every 2^W cycles
`define CPC_SLOT_DIV_W      3

// Multiface entry points and control ports
`define CPC_MF2_ENTRY       16'h0066
`define CPC_MF2_HIDE        16'h0065
`define CPC_MF2_PORT_HI     14'h3FBA
`define CPC_MF2_RAM_AW      13

// Hardware ports whose writes are shadowed
`define CPC_PORT_GA         8'h7F
`define CPC_PORT_CRTC_SEL   8'hBC
`define CPC_PORT_CRTC_VAL   8'hBD
`define CPC_PORT_PPI        8'hF7
`define CPC_PORT_UROM       8'hDF

// Shadow store addresses in Multiface RAM
`define CPC_SHADOW_PEN       13'h1FCF
`define CPC_SHADOW_BORDER    13'h1FDF
`define CPC_SHADOW_MODE      13'h1FEF
`define CPC_SHADOW_BANK      13'h1FFF
`define CPC_SHADOW_INK_BASE  9'h1F9
`define CPC_SHADOW_CRTC_SEL  13'h1CFF
`define CPC_SHADOW_CRTC_BASE 9'h1DB
`define CPC_SHADOW_PPI       13'h17FF
`define CPC_SHADOW_UROM      13'h1AAC

`endif

//--- hdl/cpc_pkg.sv
// Shared bus, download, memory request and Multiface types for the CPC expansion block
package cpc_pkg;

	// One snapshot of the Z80 bus
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        m1;
		logic        rd;
		logic        wr;
		logic        iorq;
	} cpu_bus_t;

	// Host download stream
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
		logic [7:0]  index;
		logic [15:0] file_ext;
	} host_dl_t;

	// Write request towards the memory controller
	typedef struct packed {
		logic        wr;
		logic [22:0] addr;
		logic [1:0]  bank;
		logic [7:0]  data;
	} mem_wr_t;

	typedef struct packed {
		logic hidden;
		logic disabled;
	} mf2_cfg_t;

	// Gate array command byte, pen index in arg[4:0]
	typedef struct packed {
		logic [1:0] func;
		logic [5:0] arg;
	} ga_fields_t;

	typedef union packed {
		ga_fields_t ga;
		logic [7:0] raw;
	} ga_cmd_u;

	// Lower 16K paging selects
	typedef struct packed {
		logic rom_sel;
		logic ram_sel;
	} mf2_page_t;

endpackage

//--- hdl/rom_loader.sv
// ROM loader turning host download bytes into paged memory writes and the upper ROM map
`timescale 1ns/10ps
`include "cpc_settings.svh"

module rom_loader import cpc_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  host_dl_t       dl,
	output logic           dl_wait,
	output mem_wr_t        mem,
	output logic [255:0]   rom_map
);

	logic [`CPC_SLOT_DIV_W-1:0] slot_div;
	logic       slot;
	logic       rom_dl;
	logic       dl_start;
	logic       old_active;
	logic [8:0] page;
	logic       combo;
	logic       dual;
	logic [10:0] sys_chunk;
	logic [8:0] sys_page;
	logic [4:0] hi_nib;
	logic [4:0] lo_nib;
	logic [8:0] ext_page;
	logic       ext_combo;
	logic       slot_end;
	logic       copy_again;
	logic       wr_done;

	// Hex character to nibble, bit 4 flags a valid digit
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_dl    = dl.active && (dl.index[4:0] < 5'd4);
	assign dl_start  = rom_dl && !old_active;
	assign sys_chunk = dl.addr[24:14];

	// OS, BASIC, AMSDOS, MF2 repeat for both models
	always_comb begin
		case (sys_chunk[1:0])
			2'd0: sys_page = `CPC_PAGE_OS;
			2'd1: sys_page = `CPC_PAGE_BASIC;
			2'd2: sys_page = `CPC_PAGE_AMSDOS;
			default: sys_page = `CPC_PAGE_MF2;
		endcase
	end

	assign hi_nib = hex_nibble(dl.file_ext[15:8]);
	assign lo_nib = hex_nibble(dl.file_ext[7:0]);

	// Expansion page from the two extension characters
	always_comb begin
		ext_page  = `CPC_PAGE_BADEXT;
		ext_combo = 1'b0;
		if (hi_nib[4] && lo_nib[4])
			ext_page = {1'b1, hi_nib[3:0], lo_nib[3:0]};
		// ZZ and Z0 load over the system area
		if (dl.file_ext == "ZZ")
			ext_page = `CPC_PAGE_OS;
		if (dl.file_ext == "Z0") begin
			ext_page  = `CPC_PAGE_OS;
			ext_combo = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Memory slot timing
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			slot_div <= '0;
		else
			slot_div <= slot_div + 1'b1;
	end

	assign slot       = (slot_div == '0);
	assign slot_end   = slot && mem.wr && dl_wait;
	assign copy_again = dual && (mem.bank == 2'd0);
	assign wr_done    = slot_end && !copy_again;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait    <= 1'b0;
			mem.wr     <= 1'b0;
			old_active <= 1'b0;
			combo      <= 1'b0;
			page       <= `CPC_PAGE_BADEXT;
		end else begin
			old_active <= dl.active;

			if (rom_dl && dl.wr) begin
				dl_wait        <= 1'b1;
				mem.data       <= dl.data;
				mem.addr[13:0] <= dl.addr[13:0];
				dual           <= (dl.index[7:6] == 2'd1);
				if (dl.index != 8'd0) begin
					mem.addr[22]    <= page[8];
					mem.addr[21:14] <= page[7:0] + dl.addr[21:14];
					mem.bank        <= {1'b0, &dl.index[7:6]};
				end else if (sys_chunk < 11'd8) begin
					mem.addr[22:14] <= sys_page;
					// Chunks 4..7 are the 664 set in bank 1
					mem.bank        <= {1'b0, sys_chunk[2]};
				end else begin
					dl_wait <= 1'b0;
				end
			end

			if (slot) begin
				mem.wr <= dl_wait;
				if (slot_end) begin
					mem.wr <= 1'b0;
					if (copy_again)
						mem.bank <= 2'd1;
					else
						dl_wait <= 1'b0;
				end
			end

			// Combo image moves on after its first 16K
			if (wr_done && combo && (&mem.addr[13:0])) begin
				combo <= 1'b0;
				page  <= `CPC_PAGE_COMBO_END;
			end

			if (dl_start && (dl.index != 8'd0)) begin
				page  <= ext_page;
				combo <= ext_combo;
			end
		end
	end

	// Present upper ROMs, kept across reset
	always_ff @(posedge clk_sys) begin
		if (dl_start && (dl.index == 8'd0))
			rom_map <= '0;
		else if (wr_done && mem.addr[22])
			rom_map[mem.addr[21:14]] <= 1'b1;
	end

endmodule

//--- hdl/mf2_control.sv
// Multiface Two NMI arming, enable and hidden state plus lower 16K paging selects
`timescale 1ns/10ps
`include "cpc_settings.svh"

module mf2_control import cpc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  mf2_cfg_t  cfg,
	input  cpu_bus_t  bus,
	input  logic      key_nmi,
	output logic      nmi,
	output logic      active,
	output mf2_page_t page
);

	logic old_key;
	logic old_m1;
	logic old_io_wr;
	logic hidden;
	logic io_wr;
	logic key_edge;
	logic m1_edge;
	logic io_wr_edge;
	logic port_hit;
	logic at_entry;
	logic at_hide;

	assign io_wr = bus.wr && bus.iorq;

	// Rising edges against the registered copies
	assign key_edge   = key_nmi && !old_key;
	assign m1_edge    = bus.m1 && !old_m1;
	assign io_wr_edge = io_wr && !old_io_wr;

	// FEE8h enables, FEEAh disables
	assign port_hit = (bus.addr[15:2] == `CPC_MF2_PORT_HI);
	assign at_entry = (bus.addr == `CPC_MF2_ENTRY);
	assign at_hide  = (bus.addr == `CPC_MF2_HIDE);

	//////////////////////////////////////////////////
	// Multiface state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key   <= 1'b0;
			old_m1    <= 1'b0;
			old_io_wr <= 1'b0;
			nmi       <= 1'b0;
			active    <= 1'b0;
			hidden    <= cfg.hidden || cfg.disabled;
		end else begin
			old_key   <= key_nmi;
			old_m1    <= bus.m1;
			old_io_wr <= io_wr;

			// Freeze key arms the NMI
			if (key_edge && !active && !cfg.disabled)
				nmi <= 1'b1;

			// NMI vector fetch pages the Multiface in
			if (nmi && m1_edge && at_entry) begin
				active <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (active && m1_edge && at_hide)
				hidden <= 1'b1;

			if (io_wr_edge && port_hit)
				active <= !bus.addr[1] && !hidden && !cfg.disabled;
		end
	end

	// ROM at 0000h-1FFFh, RAM at 2000h-3FFFh
	assign page.rom_sel = active && (bus.addr[15:13] == 3'b000);
	assign page.ram_sel = active && (bus.addr[15:13] == 3'b001);

endmodule

//--- hdl/mf2_shadow.sv
// Multiface Two 8 KB RAM with shadow copies of gate array, CRTC, 8255 and upper ROM writes
`timescale 1ns/10ps
`include "cpc_settings.svh"

module mf2_shadow import cpc_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  cpu_bus_t                   bus,
	input  logic                       active,
	input  logic [`CPC_MF2_RAM_AW-1:0] mem_addr,
	output logic [7:0]                 dout
);

	logic [7:0] ram [0:(1 << `CPC_MF2_RAM_AW) - 1];

	ga_cmd_u    cmd;
	logic       io_wr;
	logic       old_io_wr;
	logic       wr_edge;
	logic       ram_sel;
	logic [4:0] pen_index;
	logic [3:0] crtc_reg;
	logic [`CPC_MF2_RAM_AW-1:0] store_addr;
	logic [`CPC_MF2_RAM_AW-1:0] ram_a;
	logic [7:0] ram_in;
	logic [7:0] ram_out;
	logic       ram_we;

	assign cmd.raw = bus.dout;
	assign io_wr   = bus.wr && bus.iorq;
	assign wr_edge = io_wr && !old_io_wr;
	assign ram_sel = active && (bus.addr[15:13] == 3'b001);

	//////////////////////////////////////////////////
	// Shadow slot decode
	//////////////////////////////////////////////////

	// Zero means the port is not shadowed
	always_comb begin
		store_addr = '0;
		case (bus.addr[15:8])
			`CPC_PORT_GA: begin
				case (cmd.ga.func)
					2'b00: store_addr = `CPC_SHADOW_PEN;
					2'b01: store_addr = pen_index[4] ? `CPC_SHADOW_BORDER
					                                 : {`CPC_SHADOW_INK_BASE, pen_index[3:0]};
					2'b10: store_addr = `CPC_SHADOW_MODE;
					default: store_addr = `CPC_SHADOW_BANK;
				endcase
			end
			`CPC_PORT_CRTC_SEL: store_addr = `CPC_SHADOW_CRTC_SEL;
			`CPC_PORT_CRTC_VAL: store_addr = {`CPC_SHADOW_CRTC_BASE, crtc_reg};
			`CPC_PORT_PPI:      store_addr = `CPC_SHADOW_PPI;
			`CPC_PORT_UROM:     store_addr = `CPC_SHADOW_UROM;
			default:            store_addr = '0;
		endcase
	end

	// Last pen and CRTC register selected by the CPU
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			if (bus.addr[15:8] == `CPC_PORT_GA && cmd.ga.func == 2'b00)
				pen_index <= cmd.ga.arg[4:0];
			if (bus.addr[15:8] == `CPC_PORT_CRTC_SEL)
				crtc_reg <= cmd.raw[3:0];
		end
	end

	//////////////////////////////////////////////////
	// RAM port
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_io_wr <= 1'b0;
			ram_we    <= 1'b0;
		end else begin
			old_io_wr <= io_wr;
			ram_we    <= 1'b0;
			ram_a     <= mem_addr;
			if (wr_edge && (store_addr != '0)) begin
				ram_a  <= store_addr;
				ram_in <= cmd.raw;
				ram_we <= 1'b1;
			end else if (bus.wr && !bus.iorq && ram_sel) begin
				// Plain CPU write into Multiface RAM
				ram_in <= bus.dout;
				ram_we <= 1'b1;
			end
		end
	end

	// Write-through read register
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	assign dout = (ram_sel && bus.rd && !bus.iorq) ? ram_out : 8'hFF;

endmodule

//--- hdl/cpc_expansion.sv
// CPC expansion top joining the ROM loader with the Multiface Two control and RAM
`timescale 1ns/10ps

module cpc_expansion import cpc_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,

	// Host download
	input  host_dl_t      dl,
	output logic          dl_wait,

	// Memory controller side
	output mem_wr_t       mem,
	output logic [255:0]  rom_map,

	// CPU side
	input  cpu_bus_t      bus,
	input  logic [12:0]   mem_addr,
	input  logic          key_nmi,
	input  mf2_cfg_t      cfg,
	output logic          nmi,
	output mf2_page_t     page,
	output logic [7:0]    mf2_dout
);

	logic mf2_active;

	//////////////////////////////////////////////////
	// ROM download
	//////////////////////////////////////////////////

	rom_loader u_rom_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.dl_wait (dl_wait),
		.mem     (mem),
		.rom_map (rom_map)
	);

	//////////////////////////////////////////////////
	// Multiface Two
	//////////////////////////////////////////////////

	mf2_control u_mf2_control (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cfg     (cfg),
		.bus     (bus),
		.key_nmi (key_nmi),
		.nmi     (nmi),
		.active  (mf2_active),
		.page    (page)
	);

	// RAM select is decoded inside from active and the address
	mf2_shadow u_mf2_shadow (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.active   (mf2_active),
		.mem_addr (mem_addr),
		.dout     (mf2_dout)
	);

endmodule

//--- verif/tb_cpc_expansion.sv
// Testbench for the CPC expansion block covering ROM loading and the Multiface Two
`timescale 1ns/10ps

module tb_cpc_expansion import cpc_pkg::*; ();

	logic         clk_sys = 1'b0;
	logic         reset;
	host_dl_t     dl;
	logic         dl_wait;
	mem_wr_t      mem;
	logic [255:0] rom_map;
	cpu_bus_t     bus;
	logic [12:0]  mem_addr;
	logic         key_nmi;
	mf2_cfg_t     cfg;
	logic         nmi;
	mf2_page_t    page;
	logic [7:0]   mf2_dout;

	integer       seed = 32'h5908;
	logic [31:0]  rnd;
	int           err_count = 0;
	int           wait_prop_fails = 0;
	int           tests_run = 0;
	int           tests_failed = 0;
	int           first_err;
	mem_wr_t      writes [$];
	logic         wr_seen;

	always #4 clk_sys = ~clk_sys;

	cpc_expansion u_cpc_expansion (
		.clk_sys (clk_sys), .reset (reset), .dl (dl), .dl_wait (dl_wait),
		.mem (mem), .rom_map (rom_map), .bus (bus), .mem_addr (mem_addr),
		.key_nmi (key_nmi), .cfg (cfg), .nmi (nmi), .page (page), .mf2_dout (mf2_dout)
	);

	// One entry per rising edge of the write strobe
	always @(posedge clk_sys) begin
		if (!reset && mem.wr && !wr_seen)
			writes.push_back(mem);
		wr_seen <= mem.wr;
	end

	wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset) mem.wr |-> dl_wait)
		else begin
			$display("Fail at %0t: memory write strobe while dl_wait is low", $time);
			wait_prop_fails++;
		end

	//////////////////////////////////////////////////
	// Checks and bookkeeping
	//////////////////////////////////////////////////

	function automatic int total_errors();
		return err_count + wait_prop_fails;
	endfunction

	// OS, BASIC, AMSDOS, Multiface for chunk mod 4
	function automatic logic [8:0] system_page(input int chunk);
		case (chunk % 4)
			0: return 9'h000;
			1: return 9'h100;
			2: return 9'h107;
			default: return 9'h0FF;
		endcase
	endfunction

	task automatic expect_true(input logic ok, input string what);
		assert (ok) else begin
			$display("Fail at %0t: %s", $time, what);
			err_count++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout waiting for %s", what);
		err_count++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (total_errors() != first_err) begin
			tests_failed++;
			$display("%-26s failed, %0d errors", name, total_errors() - first_err);
		end else begin
			$display("%-26s ok", name);
		end
	endtask

	task automatic compare_write(input int at, input logic [8:0] pg, input logic [1:0] bank,
			input logic [13:0] offs, input logic [7:0] data, input string what);
		mem_wr_t w;
		if (writes.size() <= at) begin
			$display("No memory write was seen for %s", what);
			err_count++;
		end else begin
			w = writes[at];
			expect_true(w.addr == {pg, offs} && w.bank == bank && w.data == data,
				$sformatf("%s wrote %06h bank %0d data %02h", what, w.addr, w.bank, w.data));
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Active low for a cycle so the loader sees a new download
	task automatic start_download(input logic [7:0] index, input logic [15:0] ext);
		@(posedge clk_sys);
		dl.active <= 1'b0;
		@(posedge clk_sys);
		dl.index    <= index;
		dl.file_ext <= ext;
		dl.active   <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		int n;
		@(posedge clk_sys);
		dl.addr <= addr;
		dl.data <= data;
		dl.wr   <= 1'b1;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(posedge clk_sys);
		n = 0;
		while (dl_wait && n < 64) begin
			@(posedge clk_sys);
			n++;
		end
		if (dl_wait)
			note_timeout("the loader to drop dl_wait");
	endtask

	task automatic cpu_m1(input logic [15:0] addr);
		@(posedge clk_sys);
		bus.addr <= addr;
		bus.m1   <= 1'b1;
		@(posedge clk_sys);
		bus.m1 <= 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		bus.addr <= addr;
		bus.dout <= data;
		bus.iorq <= 1'b1;
		bus.wr   <= 1'b1;
		@(posedge clk_sys);
		bus.iorq <= 1'b0;
		bus.wr   <= 1'b0;
	endtask

	task automatic press_key();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		@(posedge clk_sys);
		key_nmi <= 1'b0;
	endtask

	task automatic wait_nmi(input logic level, input string what);
		int n;
		n = 0;
		while (nmi != level && n < 32) begin
			@(posedge clk_sys);
			n++;
		end
		if (nmi != level)
			note_timeout({"nmi after ", what});
	endtask

	task automatic nmi_stays_low(input string what);
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < 16; n++) begin
			@(posedge clk_sys);
			seen = seen | nmi;
		end
		expect_true(!seen, {"nmi raised ", what});
	endtask

	// ROM select probed at 0000h, RAM select at 2000h
	task automatic check_selects(input logic rom, input logic ram, input string what);
		@(posedge clk_sys);
		bus.addr <= 16'h0000;
		@(posedge clk_sys);
		expect_true(page.rom_sel == rom, {"ROM select wrong ", what});
		bus.addr <= 16'h2000;
		@(posedge clk_sys);
		expect_true(page.ram_sel == ram, {"RAM select wrong ", what});
	endtask

	// Registered address, then registered data
	task automatic read_shadow(input logic [12:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		bus.addr <= {3'b001, addr};
		bus.rd   <= 1'b1;
		mem_addr <= addr;
		repeat (3) @(posedge clk_sys);
		data = mf2_dout;
		bus.rd <= 1'b0;
	endtask

	initial begin
		int base;
		logic [7:0] got;
		dl       <= '0;
		bus      <= '0;
		mem_addr <= '0;
		key_nmi  <= 1'b0;
		cfg      <= '0;
		reset    <= 1'b1;
		apply_reset();

		first_err = total_errors();
		start_download(8'h00, "00");
		for (int c = 0; c < 8; c++) begin
			rnd = $random(seed);
			base = writes.size();
			send_byte({11'(c), rnd[13:0]}, rnd[21:14]);
			expect_true(writes.size() == base + 1, $sformatf("chunk %0d write count", c));
			compare_write(base, system_page(c), (c < 4) ? 2'd0 : 2'd1, rnd[13:0], rnd[21:14],
				$sformatf("system chunk %0d", c));
		end
		base = writes.size();
		send_byte({11'd8, 14'h0000}, 8'h5A);
		expect_true(writes.size() == base && !dl_wait, "chunk 8 must not write");
		finish_test("system ROM mapping");

		first_err = total_errors();
		start_download(8'h03, "2B");
		rnd = $random(seed);
		base = writes.size();
		send_byte({11'd0, rnd[13:0]}, rnd[21:14]);
		compare_write(base, 9'h100 + 9'h02B, 2'd0, rnd[13:0], rnd[21:14], "ROM 2Bh chunk 0");
		expect_true(rom_map[8'h2B], "rom_map bit 2Bh not set");
		base = writes.size();
		send_byte({11'd1, rnd[13:0]}, rnd[21:14]);
		compare_write(base, 9'h100 + 9'h02B + 9'd1, 2'd0, rnd[13:0], rnd[21:14],
			"ROM 2Bh chunk 1");
		start_download(8'h40, "2B");
		base = writes.size();
		send_byte({11'd0, rnd[13:0]}, rnd[21:14]);
		expect_true(writes.size() == base + 2, "dual bank copy write count");
		compare_write(base, 9'h12B, 2'd0, rnd[13:0], rnd[21:14], "dual copy bank 0");
		compare_write(base + 1, 9'h12B, 2'd1, rnd[13:0], rnd[21:14], "dual copy bank 1");
		start_download(8'h03, "Q1");
		base = writes.size();
		send_byte({11'd0, rnd[13:0]}, rnd[21:14]);
		compare_write(base, 9'h1EE, 2'd0, rnd[13:0], rnd[21:14], "malformed extension");
		finish_test("expansion page naming");

		first_err = total_errors();
		press_key();
		wait_nmi(1'b1, "key edge");
		cpu_m1(16'h0066);
		wait_nmi(1'b0, "entry fetch");
		check_selects(1'b1, 1'b1, "after entry");
		io_write(16'hFEEA, 8'h00);
		check_selects(1'b0, 1'b0, "after FEEAh");
		io_write(16'hFEE8, 8'h00);
		check_selects(1'b1, 1'b1, "after FEE8h");
		cpu_m1(16'h0065);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		check_selects(1'b0, 1'b0, "while hidden");
		finish_test("NMI entry and ports");

		first_err = total_errors();
		press_key();
		wait_nmi(1'b1, "key edge");
		cpu_m1(16'h0066);
		io_write(16'h7F00, 8'h03);
		rnd = $random(seed);
		io_write(16'h7F00, {2'b01, rnd[5:0]});
		read_shadow(13'h1F93, got);
		expect_true(got == {2'b01, rnd[5:0]}, $sformatf("ink 3 shadow read %02h", got));
		io_write(16'hBC00, 8'd12);
		io_write(16'hBD00, rnd[15:8]);
		read_shadow(13'h1DBC, got);
		expect_true(got == rnd[15:8], $sformatf("CRTC R12 shadow read %02h", got));
		finish_test("register shadowing");

		first_err = total_errors();
		@(posedge clk_sys);
		cfg.hidden   <= 1'b0;
		cfg.disabled <= 1'b1;
		apply_reset();
		press_key();
		nmi_stays_low("while disabled");
		io_write(16'hFEE8, 8'h00);
		check_selects(1'b0, 1'b0, "FEE8h while disabled");
		@(posedge clk_sys);
		cfg.hidden   <= 1'b1;
		cfg.disabled <= 1'b0;
		apply_reset();
		io_write(16'hFEE8, 8'h00);
		check_selects(1'b0, 1'b0, "FEE8h while hidden");
		press_key();
		wait_nmi(1'b1, "key edge while hidden");
		cpu_m1(16'h0066);
		check_selects(1'b1, 1'b1, "entry while hidden");
		finish_test("configuration");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- cpc_expansion.f
+incdir+hdl
hdl/cpc_pkg.sv
hdl/rom_loader.sv
hdl/mf2_control.sv
hdl/mf2_shadow.sv
hdl/cpc_expansion.sv
verif/tb_cpc_expansion.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpc_expansion
FILELIST = cpc_expansion.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
